// ==== hw/serial_acc_macros.svh ====
// Sizes are fixed by the opcode byte layout; changing SA_WORD_W alone breaks opcode decoding
`ifndef SERIAL_ACC_MACROS_SVH
`define SERIAL_ACC_MACROS_SVH

// Serial word, accumulator and operand width
`define SA_WORD_W 8

// Opcode field in the low bits of the opcode byte
// The remaining upper bits must be zero for a legal opcode
`define SA_OP_W 3

// Bit counters in the deserializer and the result shifter
// Must hold the value SA_WORD_W itself
`define SA_CNT_W 4

`endif

// ==== hw/serial_acc_pkg.sv ====
// Opcode encodings are part of the host protocol; OP_ILLEGAL is never issued to the datapath
`default_nettype none

`include "serial_acc_macros.svh"

package serial_acc_pkg;

    // Operation selected by the low bits of an opcode byte
    typedef enum logic [`SA_OP_W-1:0] {
        OP_LOAD    = 3'd0,
        OP_ADD     = 3'd1,
        OP_SUB     = 3'd2,
        OP_AND     = 3'd3,
        OP_OR      = 3'd4,
        OP_XOR     = 3'd5,
        OP_ROL     = 3'd6,
        OP_ILLEGAL = 3'd7
    } acc_op_e;

    // Decoder position within an opcode/operand pair
    typedef enum logic {
        DEC_OPCODE  = 1'b0,
        DEC_OPERAND = 1'b1
    } dec_state_e;

endpackage

`default_nettype wire

// ==== hw/ser2par.sv ====
// Word alignment is fixed at reset with no framing recovery; word_valid lags the last bit by 3 edges
`timescale 1ns/10ps
`default_nettype none

`include "serial_acc_macros.svh"

module ser2par (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   en,
    input  wire                   ser_in,
    output logic [`SA_WORD_W-1:0] word,
    output logic                  word_valid
);

    // Stage 1 shift state
    logic [`SA_WORD_W-1:0] shift_s1;
    logic [`SA_CNT_W-1:0]  bit_cnt_s1;
    logic                  last_s1;

    // Stage 2 carried state
    logic [`SA_WORD_W-1:0] shift_s2;
    logic                  last_s2;

    // Stage 3 completed word
    logic [`SA_WORD_W-1:0] word_s3;
    logic                  valid_s3;

    // Stage 1: shift on every enabled bit, first bit ends up as MSB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_s1   <= '0;
            bit_cnt_s1 <= '0;
            last_s1    <= 1'b0;
        end else begin
            last_s1 <= en && (bit_cnt_s1 == `SA_CNT_W'(`SA_WORD_W - 1));
            if (en) begin
                shift_s1 <= {shift_s1[`SA_WORD_W-2:0], ser_in};
                // Wrap after a full word of enabled bits
                if (bit_cnt_s1 == `SA_CNT_W'(`SA_WORD_W - 1)) begin
                    bit_cnt_s1 <= '0;
                end else begin
                    bit_cnt_s1 <= bit_cnt_s1 + 1'b1;
                end
            end
        end
    end

    // Stage 2: carry shift state forward
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_s2 <= '0;
            last_s2  <= 1'b0;
        end else begin
            shift_s2 <= shift_s1;
            last_s2  <= last_s1;
        end
    end

    // Stage 3: capture the word when its last bit has passed through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_s3  <= '0;
            valid_s3 <= 1'b0;
        end else begin
            valid_s3 <= last_s2;
            if (last_s2) begin
                word_s3 <= shift_s2;
            end
        end
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word       <= '0;
            word_valid <= 1'b0;
        end else begin
            word       <= word_s3;
            word_valid <= valid_s3;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cmd_decode.sv ====
// Words must alternate opcode then operand; an illegal pair is consumed whole and reported once
`timescale 1ns/10ps
`default_nettype none

`include "serial_acc_macros.svh"

module cmd_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [`SA_WORD_W-1:0]    word,
    input  wire                     word_valid,
    output serial_acc_pkg::acc_op_e cmd_op,
    output logic [`SA_WORD_W-1:0]   cmd_operand,
    output logic                    cmd_valid,
    output logic                    cmd_error
);

    import serial_acc_pkg::*;

    dec_state_e state;
    acc_op_e    op_q;
    logic       legal_q;
    logic       word_legal;

    // Upper bits clear and a defined operation in the low field
    assign word_legal = (word[`SA_WORD_W-1:`SA_OP_W] == '0) &&
                        (acc_op_e'(word[`SA_OP_W-1:0]) != OP_ILLEGAL);

    // Pairing FSM with the strobes registered alongside
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DEC_OPCODE;
            legal_q   <= 1'b0;
            cmd_valid <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            cmd_error <= 1'b0;
            if (word_valid) begin
                case (state)
                    DEC_OPCODE: begin
                        legal_q <= word_legal;
                        state   <= DEC_OPERAND;
                    end
                    DEC_OPERAND: begin
                        // Report on the operand so the pair is always dropped together
                        cmd_valid <= legal_q;
                        cmd_error <= !legal_q;
                        state     <= DEC_OPCODE;
                    end
                    default: begin
                        state <= DEC_OPCODE;
                    end
                endcase
            end
        end
    end

    // Opcode and operand payload
    always_ff @(posedge clk) begin
        if (word_valid) begin
            if (state == DEC_OPCODE) begin
                op_q <= acc_op_e'(word[`SA_OP_W-1:0]);
            end else begin
                cmd_op      <= op_q;
                cmd_operand <= word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/acc_execute.sv ====
// Arithmetic wraps modulo 2**SA_WORD_W; only legal opcodes may arrive with cmd_valid
`timescale 1ns/10ps
`default_nettype none

`include "serial_acc_macros.svh"

module acc_execute (
    input  wire                     clk,
    input  wire                     rst_n,
    input  serial_acc_pkg::acc_op_e cmd_op,
    input  wire [`SA_WORD_W-1:0]    cmd_operand,
    input  wire                     cmd_valid,
    output logic [`SA_WORD_W-1:0]   acc_value,
    output logic                    acc_valid
);

    import serial_acc_pkg::*;

    // Rotate amount taken from the operand low bits
    localparam int ROT_W = $clog2(`SA_WORD_W);

    logic [`SA_WORD_W-1:0]   acc_next;
    logic [2*`SA_WORD_W-1:0] rol_wide;
    logic [ROT_W-1:0]        rot_amt;

    assign rot_amt = cmd_operand[ROT_W-1:0];

    // Doubled copy shifted left, upper half is the rotated value
    assign rol_wide = {acc_value, acc_value} << rot_amt;

    always_comb begin
        case (cmd_op)
            OP_LOAD: acc_next = cmd_operand;
            OP_ADD:  acc_next = acc_value + cmd_operand;
            OP_SUB:  acc_next = acc_value - cmd_operand;
            OP_AND:  acc_next = acc_value & cmd_operand;
            OP_OR:   acc_next = acc_value | cmd_operand;
            OP_XOR:  acc_next = acc_value ^ cmd_operand;
            OP_ROL:  acc_next = rol_wide[2*`SA_WORD_W-1:`SA_WORD_W];
            // decoder never issues this one, hold the value
            default: acc_next = acc_value;
        endcase
    end

    // Write back and strobe the new value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_value <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= cmd_valid;
            if (cmd_valid) begin
                acc_value <= acc_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/result_serializer.sv ====
// No back-pressure; a new value arriving mid-shift restarts the output with that value
`timescale 1ns/10ps
`default_nettype none

`include "serial_acc_macros.svh"

module result_serializer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [`SA_WORD_W-1:0] acc_value,
    input  wire                  acc_valid,
    output logic                 ser_out,
    output logic                 ser_out_valid
);

    logic [`SA_WORD_W-1:0] shift_q;
    logic [`SA_CNT_W-1:0]  bits_left;

    // Load on a new value, otherwise shift left until the count runs out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bits_left <= '0;
        end else if (acc_valid) begin
            bits_left <= `SA_CNT_W'(`SA_WORD_W);
        end else if (bits_left != '0) begin
            bits_left <= bits_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            shift_q <= acc_value;
        end else if (bits_left != '0) begin
            shift_q <= {shift_q[`SA_WORD_W-2:0], 1'b0};
        end
    end

    // MSB first, valid for exactly one word of cycles
    assign ser_out       = shift_q[`SA_WORD_W-1];
    assign ser_out_valid = (bits_left != '0);

endmodule

`default_nettype wire

// ==== hw/serial_acc_top.sv ====
// Results leave in 8 cycles and commands need 16 enabled bits, so outputs never overlap
`timescale 1ns/10ps
`default_nettype none

`include "serial_acc_macros.svh"

module serial_acc_top (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  en,
    input  wire  ser_in,
    output logic ser_out,
    output logic ser_out_valid,
    output logic cmd_error
);

    import serial_acc_pkg::*;

    logic [`SA_WORD_W-1:0] word;
    logic                  word_valid;
    acc_op_e               cmd_op;
    logic [`SA_WORD_W-1:0] cmd_operand;
    logic                  cmd_valid;
    logic [`SA_WORD_W-1:0] acc_value;
    logic                  acc_valid;

    ser2par u_ser2par (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .ser_in     (ser_in),
        .word       (word),
        .word_valid (word_valid)
    );

    cmd_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .word        (word),
        .word_valid  (word_valid),
        .cmd_op      (cmd_op),
        .cmd_operand (cmd_operand),
        .cmd_valid   (cmd_valid),
        .cmd_error   (cmd_error)
    );

    acc_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_op      (cmd_op),
        .cmd_operand (cmd_operand),
        .cmd_valid   (cmd_valid),
        .acc_value   (acc_value),
        .acc_valid   (acc_valid)
    );

    result_serializer u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc_value     (acc_value),
        .acc_valid     (acc_valid),
        .ser_out       (ser_out),
        .ser_out_valid (ser_out_valid)
    );

endmodule

`default_nettype wire

// ==== tests/serial_acc_tb.sv ====
// One command in flight at a time; each result is fully collected before the next command is sent
`timescale 1ns/10ps
`default_nettype none

`include "serial_acc_macros.svh"

module serial_acc_tb;

    import serial_acc_pkg::*;

    typedef logic [`SA_WORD_W-1:0] byte_t;

    localparam int WAIT_LIMIT   = 200;
    localparam int QUIET_CYCLES = 16;

    logic clk;
    logic rst_n;
    logic en;
    logic ser_in;
    logic ser_out;
    logic ser_out_valid;
    logic cmd_error;

    integer seed;
    int     edge_count;
    int     errors;
    int     pass_count;
    int     fail_count;
    int     err_pulses;
    int     last_bit_edge;
    byte_t  acc_model;

    // Monitor state and collected results
    byte_t  mon_shift;
    int     mon_len;
    int     mon_rise;
    logic   mon_prev;
    logic   seen_valid;
    byte_t  res_q[$];
    int     len_q[$];
    int     rise_q[$];

    serial_acc_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .ser_in        (ser_in),
        .ser_out       (ser_out),
        .ser_out_valid (ser_out_valid),
        .cmd_error     (cmd_error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count = edge_count + 1;
    end

    // Sample mid-cycle, away from the edge where the DUT updates
    always @(negedge clk) begin
        if (cmd_error === 1'b1) begin
            err_pulses = err_pulses + 1;
        end
        if (ser_out_valid === 1'b1) begin
            seen_valid = 1'b1;
            if (!mon_prev) begin
                mon_rise = edge_count;
                mon_len  = 0;
            end
            mon_shift = {mon_shift[`SA_WORD_W-2:0], ser_out};
            mon_len   = mon_len + 1;
        end else if (mon_prev) begin
            res_q.push_back(mon_shift);
            len_q.push_back(mon_len);
            rise_q.push_back(mon_rise);
        end
        mon_prev = (ser_out_valid === 1'b1);
    end

    // Legal when the upper five bits are clear and the low field is not the reserved code
    function automatic bit is_legal(input byte_t op_byte);
        return (op_byte[7:3] == 5'd0) && (op_byte[2:0] != 3'd7);
    endfunction

    // Reference model of the accumulator rules
    function automatic byte_t next_acc(input byte_t acc, input byte_t op_byte, input byte_t arg);
        byte_t r;
        r = acc;
        if (is_legal(op_byte)) begin
            case (op_byte[2:0])
                OP_LOAD: r = arg;
                OP_ADD:  r = byte_t'(acc + arg);
                OP_SUB:  r = byte_t'(acc - arg);
                OP_AND:  r = acc & arg;
                OP_OR:   r = acc | arg;
                OP_XOR:  r = acc ^ arg;
                OP_ROL: begin
                    repeat (arg[2:0]) r = {r[6:0], r[7]};
                end
                default: r = acc;
            endcase
        end
        return r;
    endfunction

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        assert (actual === expected) else begin
            $display("Mismatch at %0t ns: %s expected %02h, got %02h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Mismatch at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // MSB first, with optional random idle cycles before each bit
    task automatic send_byte(input byte_t value, input bit gapped);
        int gap;
        for (int i = `SA_WORD_W - 1; i >= 0; i--) begin
            gap = gapped ? ($unsigned($random(seed)) % 4) : 0;
            repeat (gap) begin
                @(negedge clk);
                en     = 1'b0;
                ser_in = 1'($random(seed));
            end
            @(negedge clk);
            en     = 1'b1;
            ser_in = value[i];
        end
        last_bit_edge = edge_count + 1;
    endtask

    task automatic send_idle();
        @(negedge clk);
        en     = 1'b0;
        ser_in = 1'b0;
    endtask

    task automatic run_cmd(input byte_t op_byte, input byte_t arg, input bit gapped,
                           output byte_t got);
        byte_t expected;
        int    pulses_before;
        int    rise_expect;
        int    waited;
        @(posedge clk);
        seen_valid    = 1'b0;
        expected      = next_acc(acc_model, op_byte, arg);
        pulses_before = err_pulses;
        got           = acc_model;
        send_byte(op_byte, gapped);
        send_byte(arg, gapped);
        rise_expect = last_bit_edge + 6;
        send_idle();
        waited = 0;
        if (is_legal(op_byte)) begin
            while (res_q.size() == 0 && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (res_q.size() == 0) begin
                $display("Timeout at %0t ns: no result on ser_out for opcode %02h",
                         $time, op_byte);
                errors++;
            end else begin
                got = res_q.pop_front();
                check_byte("ser_out", expected, got);
                check_count("ser_out_valid length", `SA_WORD_W, len_q.pop_front());
                check_count("ser_out_valid rise edge", rise_expect, rise_q.pop_front());
                check_count("cmd_error pulses", pulses_before, err_pulses);
                acc_model = expected;
            end
        end else begin
            while (err_pulses == pulses_before && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (err_pulses == pulses_before) begin
                $display("Timeout at %0t ns: cmd_error never rose for opcode %02h",
                         $time, op_byte);
                errors++;
            end
            repeat (QUIET_CYCLES) @(posedge clk);
            check_count("cmd_error pulses", pulses_before + 1, err_pulses);
            assert (!seen_valid && res_q.size() == 0) else begin
                $display("Error at %0t ns: illegal opcode %02h produced a result",
                         $time, op_byte);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("Test %s: pass", name);
        end else begin
            fail_count++;
            $display("Test %s: FAIL", name);
        end
    endtask

    initial begin
        byte_t got;
        byte_t prev;
        byte_t seq_op[4];
        byte_t seq_arg[4];
        byte_t ref_res[4];
        int    start;
        seed       = 32'h3fe1;
        edge_count = 0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        err_pulses = 0;
        mon_prev   = 1'b0;
        mon_shift  = '0;
        seen_valid = 1'b0;
        acc_model  = '0;
        rst_n      = 1'b0;
        en         = 1'b0;
        ser_in     = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Outputs quiet with en low, then the accumulator reads back zero
        start = errors;
        repeat (10) @(posedge clk);
        assert (!seen_valid && err_pulses == 0) else begin
            $display("Error at %0t ns: output activity after reset with en low", $time);
            errors++;
        end
        run_cmd(8'h00, 8'h00, 1'b0, got);
        check_byte("ser_out", 8'h00, got);
        finish_test("reset_state", start);

        start = errors;
        run_cmd(8'h00, 8'hF0, 1'b0, got);
        check_byte("ser_out", 8'hF0, got);
        run_cmd(8'h01, 8'h20, 1'b0, got);
        check_byte("ser_out", 8'h10, got);
        run_cmd(8'h02, 8'h11, 1'b0, got);
        check_byte("ser_out", 8'hFF, got);
        finish_test("arithmetic", start);

        start = errors;
        run_cmd(8'h03, byte_t'($random(seed)), 1'b0, got);
        run_cmd(8'h04, byte_t'($random(seed)), 1'b0, got);
        run_cmd(8'h05, byte_t'($random(seed)), 1'b0, got);
        run_cmd(8'h06, byte_t'($random(seed)), 1'b0, got);
        // Upper operand bits must be ignored by the rotate
        run_cmd(8'h00, 8'h81, 1'b0, got);
        run_cmd(8'h06, 8'hF9, 1'b0, got);
        check_byte("ser_out", 8'h03, got);
        finish_test("logic_rotate", start);

        start = errors;
        prev  = acc_model;
        run_cmd(8'h07, 8'h55, 1'b0, got);
        run_cmd(8'h81, 8'h33, 1'b0, got);
        run_cmd(8'h04, 8'h00, 1'b0, got);
        check_byte("ser_out", prev, got);
        finish_test("illegal_opcode", start);

        start      = errors;
        seq_op     = '{8'h00, 8'h01, 8'h05, 8'h06};
        seq_arg[0] = 8'h5A;
        for (int i = 1; i < 4; i++) begin
            seq_arg[i] = byte_t'($random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            run_cmd(seq_op[i], seq_arg[i], 1'b0, ref_res[i]);
        end
        for (int i = 0; i < 4; i++) begin
            run_cmd(seq_op[i], seq_arg[i], 1'b1, got);
            check_byte("ser_out gapped", ref_res[i], got);
        end
        finish_test("gapped_input", start);

        // Rise edge and length are checked inside run_cmd
        start = errors;
        run_cmd(8'h05, 8'h0F, 1'b0, got);
        run_cmd(8'h01, 8'h01, 1'b0, got);
        finish_test("exact_latency", start);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== serial_acc.f ====
+incdir+hw
hw/serial_acc_pkg.sv
hw/ser2par.sv
hw/cmd_decode.sv
hw/acc_execute.sv
hw/result_serializer.sv
hw/serial_acc_top.sv
tests/serial_acc_tb.sv

// ==== Bender.yml ====
package:
  name: serial_acc

sources:
  - include_dirs:
      - hw
    files:
      - hw/serial_acc_pkg.sv
      - hw/ser2par.sv
      - hw/cmd_decode.sv
      - hw/acc_execute.sv
      - hw/result_serializer.sv
      - hw/serial_acc_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/serial_acc_tb.sv
